// File: rtl/coreCfgPkg.sv
// Sizing assumes power-of-two register and ROB counts; tag and index widths must match the counts
package coreCfgPkg;

  // Architectural register file
  localparam int numRegs = 8;              // Registers visible to software
  localparam int regIdxW = 3;              // Index width for numRegs

  // Reorder buffer
  localparam int robDepth = 8;             // Entries, one tag each
  localparam int robTagW  = 3;             // Tag width for robDepth

  // Datapath
  localparam int dataW = 32;               // Operand and result width

  // Scalar types shared by every block
  typedef logic [regIdxW-1:0] regIdxT;     // Register index
  typedef logic [robTagW-1:0] robTagT;     // ROB tag, also the entry index
  typedef logic [dataW-1:0]   dataT;       // Operand value

endpackage

// File: rtl/renamePkg.sv
// Struct layouts are fixed by coreCfgPkg widths; only one dispatch and one commit per cycle
package renamePkg;

  import coreCfgPkg::*;

  // Decoded instruction as seen by rename
  typedef struct packed {
    regIdxT dest;                          // Destination register
    regIdxT srcA;                          // First source register
    regIdxT srcB;                          // Second source register
  } dispatchReqT;

  // Common data bus broadcast
  typedef struct packed {
    robTagT tag;                           // Producer tag
    dataT   value;                         // Finished result
  } cdbT;

  // Resolved source operand
  // value is zero while waiting, tag is zero once ready
  typedef struct packed {
    logic   ready;                         // Value field is valid
    robTagT tag;                           // Producer still being waited on
    dataT   value;                         // Operand value
  } operandT;

  // Packet handed to a reservation station
  typedef struct packed {
    robTagT  tag;                          // Own ROB tag
    operandT opA;                          // First operand
    operandT opB;                          // Second operand
  } issueT;

  // Retiring ROB head
  typedef struct packed {
    regIdxT dest;                          // Register to update
    dataT   value;                         // Committed result
    robTagT tag;                           // Tag being retired
  } commitT;

endpackage

// File: rtl/robValueBuffer.sv
// All writes on the rising edge; same-cycle CDB data is bypassed, and a commit clear beats a CDB set
`timescale 1ns/1ps

module robValueBuffer import coreCfgPkg::*, renamePkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  robTagT rdTagA,                   // Writer tag of source A
  input  robTagT rdTagB,                   // Writer tag of source B
  input  robTagT headTag,                  // Oldest entry
  input  cdbT    cdb,
  input  logic   cdbValid,
  input  logic   clrValid,                 // Entry retires this cycle
  input  robTagT clrTag,
  output logic   rdReadyA,
  output logic   rdReadyB,
  output logic   headReady,
  output dataT   rdValueA,
  output dataT   rdValueB,
  output dataT   headValue
);

  logic readyMem [robDepth];               // Result present, per tag
  dataT valueMem [robDepth];               // Result value, per tag

  // Stored state plus CDB bypass for each read port
  always_comb begin
    rdReadyA  = readyMem[rdTagA] | (cdbValid & (cdb.tag == rdTagA));
    rdValueA  = (cdbValid && cdb.tag == rdTagA) ? cdb.value : valueMem[rdTagA];
    rdReadyB  = readyMem[rdTagB] | (cdbValid & (cdb.tag == rdTagB));
    rdValueB  = (cdbValid && cdb.tag == rdTagB) ? cdb.value : valueMem[rdTagB];
    headReady = readyMem[headTag] | (cdbValid & (cdb.tag == headTag));
    headValue = (cdbValid && cdb.tag == headTag) ? cdb.value : valueMem[headTag];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      readyMem <= '{default: 1'b0};       // No results outstanding
    end else begin
      if (cdbValid) readyMem[cdb.tag] <= 1'b1;
      if (clrValid) readyMem[clrTag] <= 1'b0; // Head may retire on its own broadcast
    end
  end

  always_ff @(posedge clk) begin
    if (cdbValid) valueMem[cdb.tag] <= cdb.value;
  end

endmodule

// File: rtl/robQueue.sv
// Push is assumed gated by robFull upstream; commits one entry per cycle, in allocation order
`timescale 1ns/1ps

module robQueue import coreCfgPkg::*, renamePkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   push,                     // Allocate tail entry
  input  regIdxT pushDest,                 // Destination of the new entry
  input  logic   headReady,                // Head result present
  input  dataT   headValue,
  output robTagT allocTag,                 // Tag the next dispatch receives
  output robTagT headTag,
  output logic   robFull,
  output logic   commitValid,
  output commitT commit
);

  robTagT             headPtr;
  robTagT             tailPtr;
  logic [robTagW:0]   count;               // Occupancy, 0 to robDepth
  regIdxT             destMem [robDepth];  // Destination per entry

  assign allocTag = tailPtr;
  assign headTag  = headPtr;
  assign robFull  = count[robTagW];        // MSB only set at robDepth
  assign commitValid = (count != '0) && headReady;

  // Head entry as it leaves the queue
  always_comb begin
    commit.dest  = destMem[headPtr];
    commit.value = headValue;
    commit.tag   = headPtr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      if (push) tailPtr <= tailPtr + 1'b1;        // Wraps with tag width
      if (commitValid) headPtr <= headPtr + 1'b1;
      case ({push, commitValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) destMem[tailPtr] <= pushDest;
  end

endmodule

// File: rtl/regStatusTable.sv
// Reads return pre-edge state; a dispatch set beats a commit clear on the same register
`timescale 1ns/1ps

module regStatusTable import coreCfgPkg::*, renamePkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   setValid,                 // Dispatch claims a register
  input  regIdxT setReg,
  input  robTagT setTag,
  input  logic   commitValid,
  input  commitT commit,
  input  regIdxT srcA,
  input  regIdxT srcB,
  output logic   busyA,
  output logic   busyB,
  output robTagT tagA,
  output robTagT tagB
);

  logic   busyMem [numRegs];               // Pending writer exists
  robTagT tagMem  [numRegs];               // Youngest writer tag

  logic   clearHit;                        // Commit retires the current writer

  assign clearHit = commitValid && busyMem[commit.dest] &&
                    (tagMem[commit.dest] == commit.tag);

  // Plain table reads
  assign busyA = busyMem[srcA];
  assign busyB = busyMem[srcB];
  assign tagA  = tagMem[srcA];             // Meaningless while not busy
  assign tagB  = tagMem[srcB];

  always_ff @(posedge clk) begin
    if (reset) begin
      busyMem <= '{default: 1'b0};
    end else begin
      // Younger writer keeps the bit set
      if (clearHit) busyMem[commit.dest] <= 1'b0;
      if (setValid) busyMem[setReg] <= 1'b1;    // Later statement wins
    end
  end

  always_ff @(posedge clk) begin
    if (setValid) tagMem[setReg] <= setTag;
  end

endmodule

// File: rtl/archRegFile.sv
// Eight registers cleared on reset; a same-cycle write is returned on matching read ports
`timescale 1ns/1ps

module archRegFile import coreCfgPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   wrValid,                  // Commit write
  input  regIdxT wrReg,
  input  dataT   wrData,
  input  regIdxT srcA,
  input  regIdxT srcB,
  output dataT   valueA,
  output dataT   valueB
);

  dataT regMem [numRegs];

  // Write-first, so a retiring value is seen by this cycle's dispatch
  assign valueA = (wrValid && wrReg == srcA) ? wrData : regMem[srcA];
  assign valueB = (wrValid && wrReg == srcB) ? wrData : regMem[srcB];

  always_ff @(posedge clk) begin
    if (reset) begin
      regMem <= '{default: '0};           // Architectural state starts at zero
    end else if (wrValid) begin
      regMem[wrReg] <= wrData;
    end
  end

endmodule

// File: rtl/operandDispatch.sv
// Accepts nothing until one edge after reset; waiting operands carry a tag and a zero value
`timescale 1ns/1ps

module operandDispatch import coreCfgPkg::*, renamePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  dispatchReqT dispReq,
  input  logic        dispValid,
  output logic        dispReady,
  output logic        dispFire,           // Handshake completes this edge
  input  robTagT      allocTag,
  input  logic        robFull,
  input  logic        busyA,
  input  logic        busyB,
  input  robTagT      tagA,
  input  robTagT      tagB,
  input  logic        bufReadyA,
  input  logic        bufReadyB,
  input  dataT        bufValueA,
  input  dataT        bufValueB,
  input  dataT        regValueA,
  input  dataT        regValueB,
  input  logic        commitValid,
  input  commitT      commit,
  output issueT       issue,
  output logic        issueValid,
  input  logic        issueReady
);

  logic  started;                          // Out of reset for one edge
  logic  retireA;                          // Writer of A commits now
  logic  retireB;
  issueT nextIssue;

  // Register value, buffered result, or wait on the producer
  function automatic operandT resolveOp(input logic busy, input logic retiring,
                                        input robTagT tag, input logic bufReady,
                                        input dataT bufValue, input dataT regValue);
    operandT op;
    op = '0;
    if (!busy || retiring) begin
      op.ready = 1'b1;
      op.value = regValue;                 // Bypassed by archRegFile on commit
    end else if (bufReady) begin
      op.ready = 1'b1;
      op.value = bufValue;                 // Finished, not yet committed
    end else begin
      op.tag = tag;
    end
    return op;
  endfunction

  assign retireA = commitValid && (commit.tag == tagA) && (commit.dest == dispReq.srcA);
  assign retireB = commitValid && (commit.tag == tagB) && (commit.dest == dispReq.srcB);

  assign dispReady = started && !robFull && (!issueValid || issueReady);
  assign dispFire  = dispValid && dispReady;

  always_comb begin
    nextIssue.tag = allocTag;
    nextIssue.opA = resolveOp(busyA, retireA, tagA, bufReadyA, bufValueA, regValueA);
    nextIssue.opB = resolveOp(busyB, retireB, tagB, bufReadyB, bufValueB, regValueB);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      started    <= 1'b0;
      issueValid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (dispFire) issueValid <= 1'b1;             // Refill, even while draining
      else if (issueReady) issueValid <= 1'b0;
    end
  end

  // Packet holds while the consumer stalls
  always_ff @(posedge clk) begin
    if (dispFire) issue <= nextIssue;
  end

endmodule

// File: rtl/renameStage.sv
// Single-issue rename slice; CDB has no back-pressure and each tag broadcasts once before commit
`timescale 1ns/1ps

module renameStage import coreCfgPkg::*, renamePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  dispatchReqT dispReq,
  input  logic        dispValid,
  output logic        dispReady,
  input  cdbT         cdb,
  input  logic        cdbValid,
  output issueT       issue,
  output logic        issueValid,
  input  logic        issueReady,
  output commitT      commit,
  output logic        commitValid
);

  logic   dispFire;                        // Allocation enable
  robTagT allocTag;
  robTagT headTag;
  logic   robFull;
  logic   headReady;
  dataT   headValue;
  logic   busyA, busyB;                    // Status of both sources
  robTagT tagA, tagB;
  logic   bufReadyA, bufReadyB;
  dataT   bufValueA, bufValueB;
  dataT   regValueA, regValueB;

  robQueue robQ (
    .clk(clk), .reset(reset),
    .push(dispFire), .pushDest(dispReq.dest),
    .headReady(headReady), .headValue(headValue),
    .allocTag(allocTag), .headTag(headTag), .robFull(robFull),
    .commitValid(commitValid), .commit(commit)
  );

  robValueBuffer valBuf (
    .clk(clk), .reset(reset),
    .rdTagA(tagA), .rdTagB(tagB), .headTag(headTag),
    .cdb(cdb), .cdbValid(cdbValid),
    .clrValid(commitValid), .clrTag(commit.tag),
    .rdReadyA(bufReadyA), .rdReadyB(bufReadyB), .headReady(headReady),
    .rdValueA(bufValueA), .rdValueB(bufValueB), .headValue(headValue)
  );

  regStatusTable status (
    .clk(clk), .reset(reset),
    .setValid(dispFire), .setReg(dispReq.dest), .setTag(allocTag),
    .commitValid(commitValid), .commit(commit),
    .srcA(dispReq.srcA), .srcB(dispReq.srcB),
    .busyA(busyA), .busyB(busyB), .tagA(tagA), .tagB(tagB)
  );

  archRegFile regFile (
    .clk(clk), .reset(reset),
    .wrValid(commitValid), .wrReg(commit.dest), .wrData(commit.value),
    .srcA(dispReq.srcA), .srcB(dispReq.srcB),
    .valueA(regValueA), .valueB(regValueB)
  );

  operandDispatch opDisp (
    .clk(clk), .reset(reset),
    .dispReq(dispReq), .dispValid(dispValid), .dispReady(dispReady), .dispFire(dispFire),
    .allocTag(allocTag), .robFull(robFull),
    .busyA(busyA), .busyB(busyB), .tagA(tagA), .tagB(tagB),
    .bufReadyA(bufReadyA), .bufReadyB(bufReadyB),
    .bufValueA(bufValueA), .bufValueB(bufValueB),
    .regValueA(regValueA), .regValueB(regValueB),
    .commitValid(commitValid), .commit(commit),
    .issue(issue), .issueValid(issueValid), .issueReady(issueReady)
  );

endmodule

// File: bench/clockGen.sv
// Free-running 8 ns clock; reset is held high for the first 10 rising edges
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                 // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;                          // Released away from the sampling edge
  end

endmodule

// File: bench/renameChecker.sv
// Samples DUT ports on the rising edge and compares against its own model of the rename state
`timescale 1ns/1ps

module renameChecker import coreCfgPkg::*, renamePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  dispatchReqT dispReq,
  input  logic        dispValid,
  input  logic        dispReady,
  input  cdbT         cdb,
  input  logic        cdbValid,
  input  issueT       issue,
  input  logic        issueValid,
  input  logic        issueReady,
  input  commitT      commit,
  input  logic        commitValid,
  input  int          testId,              // 0 before the first test
  input  logic        finished,
  output int          errorCount
);

  dataT    regs [numRegs];                 // Architectural values
  logic    busy [numRegs];
  robTagT  wtag [numRegs];                 // Youngest writer
  logic    done [robDepth];                // Result broadcast, not committed
  dataT    val  [robDepth];
  robTagT  robQ [$];                       // Allocation order
  regIdxT  robDest [$];
  issueT   expQ [$];                       // Packets owed to the consumer
  robTagT  tail;
  logic    started, expIssueValid, lastStall, expCv, expReady, fire, reported;
  issueT   lastIssue, pkt, expPkt;
  commitT  expC;
  int      curTest, testErrs, passCnt, failCnt;

  function automatic string testName(input int id);
    case (id)
      1: return "independentOps";
      2: return "waitOnProducer";
      3: return "bufferForward";
      4: return "inOrderCommit";
      5: return "youngerWriter";
      6: return "backPressure";
      default: return "none";
    endcase
  endfunction

  // Expected operand from model state plus this cycle's commit and CDB
  function automatic operandT refOperand(input regIdxT src, input logic cmtV,
                                         input commitT cmt);
    operandT op;
    robTagT  t;
    op = '0;
    t = wtag[src];
    if (cmtV && cmt.dest == src && (!busy[src] || wtag[src] == cmt.tag)) begin
      op.ready = 1'b1;
      op.value = cmt.value;                // Writer retires this cycle
    end else if (!busy[src]) begin
      op.ready = 1'b1;
      op.value = regs[src];
    end else if (cdbValid && cdb.tag == t) begin
      op.ready = 1'b1;
      op.value = cdb.value;                // Same-cycle broadcast
    end else if (done[t]) begin
      op.ready = 1'b1;
      op.value = val[t];
    end else begin
      op.tag = t;
    end
    return op;
  endfunction

  task automatic mismatch(input string what, input logic [127:0] e, input logic [127:0] a);
    $display("FAIL %s %s expected %h actual %h", testName(curTest), what, e, a);
    testErrs++;
    errorCount++;
  endtask

  task automatic problem(input string msg);
    $display("Error in %s: %s", testName(curTest), msg);
    testErrs++;
    errorCount++;
  endtask

  task automatic reportTest();
    if (expQ.size() != 0) problem("issue packets were accepted but never delivered");
    if (robQ.size() != 0) problem("instructions were never committed");
    if (testErrs == 0) begin
      $display("PASS %s", testName(curTest));
      passCnt++;
    end else begin
      $display("FAIL %s with %0d errors", testName(curTest), testErrs);
      failCnt++;
    end
    testErrs = 0;
  endtask

  initial begin
    errorCount = 0;
    curTest = 0;
    testErrs = 0;
    passCnt = 0;
    failCnt = 0;
    reported = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] = '0;
        busy[i] = 1'b0;
        wtag[i] = '0;
      end
      for (int i = 0; i < robDepth; i++) begin
        done[i] = 1'b0;
        val[i] = '0;
      end
      robQ.delete();
      robDest.delete();
      expQ.delete();
      tail = '0;
      started = 1'b0;
      expIssueValid = 1'b0;
      lastStall = 1'b0;
    end else begin
      // Head retires once its result is present
      expCv = robQ.size() > 0 && (done[robQ[0]] || (cdbValid && cdb.tag == robQ[0]));
      expC = '0;
      if (expCv) begin
        expC.dest = robDest[0];
        expC.tag = robQ[0];
        expC.value = (cdbValid && cdb.tag == robQ[0]) ? cdb.value : val[robQ[0]];
      end
      if (commitValid !== expCv) mismatch("commitValid", 128'(expCv), 128'(commitValid));
      else if (expCv && commit !== expC) mismatch("commit", 128'(expC), 128'(commit));

      expReady = started && robQ.size() < robDepth && (!expIssueValid || issueReady);
      if (dispReady !== expReady) mismatch("dispReady", 128'(expReady), 128'(dispReady));
      if (issueValid !== expIssueValid)
        mismatch("issueValid", 128'(expIssueValid), 128'(issueValid));
      if (lastStall && issue !== lastIssue) problem("issue packet changed while stalled");

      if (issueValid && issueReady) begin
        if (expQ.size() == 0) begin
          problem("a packet was issued that was never dispatched");
        end else begin
          expPkt = expQ.pop_front();
          if (issue !== expPkt) mismatch("issue", 128'(expPkt), 128'(issue));
        end
      end

      fire = dispValid && dispReady;
      if (fire) begin
        pkt.tag = tail;
        pkt.opA = refOperand(dispReq.srcA, expCv, expC);
        pkt.opB = refOperand(dispReq.srcB, expCv, expC);
        expQ.push_back(pkt);
      end
      lastStall = issueValid && !issueReady;
      lastIssue = issue;

      // Model update in the same order as the hardware edge
      if (cdbValid) begin
        done[cdb.tag] = 1'b1;
        val[cdb.tag] = cdb.value;
      end
      if (expCv) begin
        regs[expC.dest] = expC.value;
        if (busy[expC.dest] && wtag[expC.dest] == expC.tag) busy[expC.dest] = 1'b0;
        done[expC.tag] = 1'b0;
        void'(robQ.pop_front());
        void'(robDest.pop_front());
      end
      if (fire) begin
        busy[dispReq.dest] = 1'b1;         // Dispatch wins over commit
        wtag[dispReq.dest] = tail;
        robQ.push_back(tail);
        robDest.push_back(dispReq.dest);
        tail = tail + 1'b1;
      end
      expIssueValid = fire ? 1'b1 : (issueReady ? 1'b0 : expIssueValid);
      started = 1'b1;
    end

    if (testId != curTest) begin
      if (curTest != 0) reportTest();
      curTest = testId;
    end else if (finished && !reported) begin
      reportTest();
      reported = 1'b1;
      $display("Tests passed %0d, failed %0d, errors %0d", passCnt, failCnt, errorCount);
    end
  end

endmodule

// File: bench/renameTb.sv
// Drives on the falling edge with seed 923; the run is bounded by a watchdog on test lengths
`timescale 1ns/1ps

module renameTb import coreCfgPkg::*, renamePkg::*;;

  localparam int testLen [6] = '{30, 40, 50, 60, 40, 80};  // Cycles per test

  logic        clk, reset;
  dispatchReqT dispReq;
  logic        dispValid, dispReady;
  cdbT         cdb;
  logic        cdbValid;
  issueT       issue;
  logic        issueValid, issueReady;
  commitT      commit;
  logic        commitValid;
  int          testId, errorCount;
  logic        finished;

  robTagT      pending [$];                // Allocated with no result sent yet
  logic        autoCdb, manualReq;
  robTagT      manualTag;
  int          readyMode;                  // 0 random, 1 high, 2 held low
  int          allocCount, commitCnt, issuedCnt;
  robTagT      held;

  clockGen clkGen (.clk(clk), .reset(reset));

  renameStage dut0 (
    .clk(clk), .reset(reset),
    .dispReq(dispReq), .dispValid(dispValid), .dispReady(dispReady),
    .cdb(cdb), .cdbValid(cdbValid),
    .issue(issue), .issueValid(issueValid), .issueReady(issueReady),
    .commit(commit), .commitValid(commitValid)
  );

  renameChecker checker0 (
    .clk(clk), .reset(reset),
    .dispReq(dispReq), .dispValid(dispValid), .dispReady(dispReady),
    .cdb(cdb), .cdbValid(cdbValid),
    .issue(issue), .issueValid(issueValid), .issueReady(issueReady),
    .commit(commit), .commitValid(commitValid),
    .testId(testId), .finished(finished), .errorCount(errorCount)
  );

  function automatic robTagT lastTag();
    return robTagT'(allocCount - 1);        // Most recent allocation
  endfunction

  task automatic sendTag(input robTagT t);
    cdb.tag = t;
    cdb.value = $urandom;
    cdbValid = 1'b1;
    for (int i = 0; i < pending.size(); i++) begin
      if (pending[i] == t) begin
        pending.delete(i);
        break;
      end
    end
  endtask

  // CDB and consumer handshake decided once per falling edge
  always @(negedge clk) begin
    cdbValid = 1'b0;
    if (manualReq) begin
      sendTag(manualTag);
      manualReq = 1'b0;
    end else if (autoCdb && pending.size() > 0 && $urandom_range(0, 1) == 1) begin
      sendTag(pending[$urandom_range(0, pending.size() - 1)]);  // Random order
    end
    case (readyMode)
      0:       issueReady = 1'($urandom_range(0, 1));
      1:       issueReady = 1'b1;
      default: issueReady = 1'b0;
    endcase
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (commitValid) commitCnt++;
      if (issueValid && issueReady) issuedCnt++;
    end
  end

  task automatic dispatchOne(input int d, input int a, input int b);
    @(negedge clk);
    dispReq.dest = regIdxT'(d);
    dispReq.srcA = regIdxT'(a);
    dispReq.srcB = regIdxT'(b);
    dispValid = 1'b1;
    do @(posedge clk); while (!dispReady);
    pending.push_back(robTagT'(allocCount));
    allocCount++;
    @(negedge clk);
    dispValid = 1'b0;
    @(posedge clk);                        // Caller resumes away from the drive edge
  endtask

  task automatic pulseCdb(input robTagT t);
    manualReq = 1'b1;
    manualTag = t;
    @(negedge clk);
  endtask

  // Everything broadcast, committed and delivered
  task automatic drain();
    autoCdb = 1'b1;
    readyMode = 0;
    do @(negedge clk); while (commitCnt != allocCount || issuedCnt != allocCount);
    @(posedge clk);
    autoCdb = 1'b0;
    readyMode = 1;
    @(negedge clk);
  endtask

  initial begin
    int limit;
    limit = 0;
    foreach (testLen[i]) limit += testLen[i] * 4;
    #(limit * 8);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    dispReq = '0;
    dispValid = 1'b0;
    cdb = '0;
    cdbValid = 1'b0;
    issueReady = 1'b0;
    testId = 0;
    finished = 1'b0;
    autoCdb = 1'b0;
    manualReq = 1'b0;
    manualTag = '0;
    readyMode = 1;
    allocCount = 0;
    commitCnt = 0;
    issuedCnt = 0;
    void'($urandom(923));
    while (reset !== 1'b0) @(posedge clk);
    @(negedge clk);

    testId = 1;                            // Sources 0..3 are never written here
    repeat (6) dispatchOne($urandom_range(4, 7), $urandom_range(0, 3), $urandom_range(0, 3));
    drain();

    testId = 2;
    dispatchOne(1, 0, 0);
    dispatchOne(2, 1, 1);
    dispatchOne(3, 2, 1);
    drain();

    testId = 3;
    dispatchOne(5, 0, 0);                  // Blocks the head so results stay buffered
    dispatchOne(3, 0, 0);
    pulseCdb(lastTag());
    dispatchOne(4, 3, 3);
    dispatchOne(3, 4, 0);
    manualReq = 1'b1;                      // Producer broadcast with the dispatch
    manualTag = lastTag();
    dispatchOne(6, 3, 3);
    drain();

    testId = 4;
    repeat (6) dispatchOne($urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7));
    drain();
    repeat (4) dispatchOne($urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7));
    drain();

    testId = 5;
    dispatchOne(6, 0, 0);
    held = lastTag();
    dispatchOne(6, 1, 1);
    pulseCdb(held);                        // Older writer retires
    dispatchOne(7, 6, 6);
    drain();

    testId = 6;
    @(posedge clk);
    readyMode = 2;
    dispatchOne(2, 1, 0);
    fork
      dispatchOne(3, 2, 0);                // Offered while the consumer stalls
      begin
        repeat (5) @(posedge clk);
        readyMode = 1;
      end
    join
    repeat (6) dispatchOne($urandom_range(0, 7), $urandom_range(0, 7), 2);
    fork
      dispatchOne(1, 2, 3);                // Waits on a full ROB
      begin
        repeat (6) @(posedge clk);
        autoCdb = 1'b1;
        readyMode = 0;
      end
    join
    drain();

    finished = 1'b1;
    @(posedge clk);
    #1;
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/coreCfgPkg.sv
rtl/renamePkg.sv
rtl/robValueBuffer.sv
rtl/robQueue.sv
rtl/regStatusTable.sv
rtl/archRegFile.sv
rtl/operandDispatch.sv
rtl/renameStage.sv
bench/clockGen.sv
bench/renameChecker.sv
bench/renameTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the rename slice with Verilator, runs it, and checks the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module renameTb -o renameSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/renameSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
